//--- dma_bypass.f
+incdir+tests
source/dma_bypass_pkg.sv
source/dsc_cmd_decode.sv
source/dir_stat_counters.sv
source/stat_readout.sv
source/dma_bypass_top.sv
tests/tb_dma_bypass.sv

//--- source/dir_stat_counters.sv
/*
 * per-direction dma traffic counters
 * counts accepted commands, data beats and packets, and sums
 * command lengths into a software-clearable byte counter
 */
`timescale 1ns/1ps

module dir_stat_counters (
  input  logic                                  pcie_clk,
  input  logic                                  pcie_aresetn,
  // command side
  input  logic                                  cmd_fire,
  input  logic [dma_bypass_pkg::LEN_W-1:0]      cmd_len,
  // data side, engine view of the stream
  input  logic                                  beat_fire,
  input  logic                                  beat_last,
  // software clear of the length sum
  input  logic                                  reset_length,
  output logic [dma_bypass_pkg::CNT_W-1:0]      cmd_count,
  output logic [dma_bypass_pkg::CNT_W-1:0]      word_count,
  output logic [dma_bypass_pkg::CNT_W-1:0]      pkg_count,
  output logic [dma_bypass_pkg::LEN_CNT_W-1:0]  length_count
);

  logic [dma_bypass_pkg::LEN_CNT_W-1:0] len_ext;

  // length widened to the accumulator width
  assign len_ext = {{(dma_bypass_pkg::LEN_CNT_W - dma_bypass_pkg::LEN_W){1'b0}}, cmd_len};

  // event counters, wrap silently
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      cmd_count  <= '0;
      word_count <= '0;
      pkg_count  <= '0;
    end else begin
      if (cmd_fire) begin
        cmd_count <= cmd_count + 1'b1;
      end
      if (beat_fire) begin
        word_count <= word_count + 1'b1;
        if (beat_last) begin
          pkg_count <= pkg_count + 1'b1;  // one packet per last beat
        end
      end
    end
  end

  // byte length sum
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      length_count <= '0;
    end else if (reset_length) begin
      length_count <= '0;  // clear beats a same-cycle add
    end else if (cmd_fire) begin
      length_count <= length_count + len_ext;
    end
  end

endmodule

//--- source/dma_bypass_pkg.sv
/*
 * dma bypass shared definitions
 * stream and descriptor widths, command field layout,
 * statistics counter widths and readout select codes
 */
package dma_bypass_pkg;

  // command word, address in the low bits, length above it
  localparam int CMD_W   = 96;
  localparam int ADDR_W  = 64;
  localparam int LEN_W   = 32;
  localparam int LEN_LSB = 64;  // length sits at cmd[95:64]

  localparam int DATA_W = 512;  // one stream beat
  localparam int KEEP_W = 64;   // byte enables

  // statistics
  localparam int CNT_W      = 32;
  localparam int LEN_CNT_W  = 48;  // also the readout width
  localparam int STAT_SEL_W = 4;

  localparam logic [STAT_SEL_W-1:0] STAT_WR_CMD  = 4'd0;
  localparam logic [STAT_SEL_W-1:0] STAT_WR_WORD = 4'd1;
  localparam logic [STAT_SEL_W-1:0] STAT_WR_PKG  = 4'd2;
  localparam logic [STAT_SEL_W-1:0] STAT_WR_LEN  = 4'd3;
  localparam logic [STAT_SEL_W-1:0] STAT_RD_CMD  = 4'd4;
  localparam logic [STAT_SEL_W-1:0] STAT_RD_WORD = 4'd5;
  localparam logic [STAT_SEL_W-1:0] STAT_RD_PKG  = 4'd6;
  localparam logic [STAT_SEL_W-1:0] STAT_RD_LEN  = 4'd7;
  localparam logic [STAT_SEL_W-1:0] STAT_FLUSHED = 4'd8;  // reads-flushed flag in bit 0

endpackage

//--- source/dma_bypass_top.sv
/*
 * dma descriptor-bypass front end
 * user commands become c2h/h2c bypass descriptors, data streams
 * pass straight through, per-direction statistics are readable
 */
`timescale 1ns/1ps

module dma_bypass_top (
  input  logic                                    pcie_clk,
  input  logic                                    pcie_aresetn,

  // user commands
  input  logic                                    write_cmd_valid,
  output logic                                    write_cmd_ready,
  input  logic [dma_bypass_pkg::CMD_W-1:0]        write_cmd_data,
  input  logic                                    read_cmd_valid,
  output logic                                    read_cmd_ready,
  input  logic [dma_bypass_pkg::CMD_W-1:0]        read_cmd_data,

  // user write data, heads to c2h
  input  logic                                    write_data_valid,
  output logic                                    write_data_ready,
  input  logic [dma_bypass_pkg::DATA_W-1:0]       write_data_data,
  input  logic [dma_bypass_pkg::KEEP_W-1:0]       write_data_keep,
  input  logic                                    write_data_last,

  // user read data, comes from h2c
  output logic                                    read_data_valid,
  input  logic                                    read_data_ready,
  output logic [dma_bypass_pkg::DATA_W-1:0]       read_data_data,
  output logic [dma_bypass_pkg::KEEP_W-1:0]       read_data_keep,
  output logic                                    read_data_last,

  // engine c2h stream
  output logic                                    c2h_valid,
  input  logic                                    c2h_ready,
  output logic [dma_bypass_pkg::DATA_W-1:0]       c2h_data,
  output logic [dma_bypass_pkg::KEEP_W-1:0]       c2h_keep,
  output logic                                    c2h_last,

  // engine h2c stream
  input  logic                                    h2c_valid,
  output logic                                    h2c_ready,
  input  logic [dma_bypass_pkg::DATA_W-1:0]       h2c_data,
  input  logic [dma_bypass_pkg::KEEP_W-1:0]       h2c_keep,
  input  logic                                    h2c_last,

  // descriptor bypass, c2h engine
  input  logic                                    c2h_dsc_byp_ready,
  output logic                                    c2h_dsc_byp_load,
  output logic [dma_bypass_pkg::ADDR_W-1:0]       c2h_dsc_byp_addr,
  output logic [dma_bypass_pkg::LEN_W-1:0]        c2h_dsc_byp_len,

  // descriptor bypass, h2c engine
  input  logic                                    h2c_dsc_byp_ready,
  output logic                                    h2c_dsc_byp_load,
  output logic [dma_bypass_pkg::ADDR_W-1:0]       h2c_dsc_byp_addr,
  output logic [dma_bypass_pkg::LEN_W-1:0]        h2c_dsc_byp_len,

  // statistics access
  input  logic [dma_bypass_pkg::STAT_SEL_W-1:0]   stat_sel,
  input  logic                                    reset_write_length,
  input  logic                                    reset_read_length,
  output logic [dma_bypass_pkg::LEN_CNT_W-1:0]    stat_value
);

  logic write_cmd_fire;
  logic read_cmd_fire;
  logic write_beat_fire;
  logic read_beat_fire;

  logic [dma_bypass_pkg::CNT_W-1:0]     wr_cmd_count;
  logic [dma_bypass_pkg::CNT_W-1:0]     wr_word_count;
  logic [dma_bypass_pkg::CNT_W-1:0]     wr_pkg_count;
  logic [dma_bypass_pkg::LEN_CNT_W-1:0] wr_length_count;
  logic [dma_bypass_pkg::CNT_W-1:0]     rd_cmd_count;
  logic [dma_bypass_pkg::CNT_W-1:0]     rd_word_count;
  logic [dma_bypass_pkg::CNT_W-1:0]     rd_pkg_count;
  logic [dma_bypass_pkg::LEN_CNT_W-1:0] rd_length_count;

  // write data goes to c2h untouched
  assign c2h_valid        = write_data_valid;
  assign c2h_data         = write_data_data;
  assign c2h_keep         = write_data_keep;
  assign c2h_last         = write_data_last;
  assign write_data_ready = c2h_ready;

  // h2c goes to read data untouched
  assign read_data_valid = h2c_valid;
  assign read_data_data  = h2c_data;
  assign read_data_keep  = h2c_keep;
  assign read_data_last  = h2c_last;
  assign h2c_ready       = read_data_ready;

  // handshakes seen by the statistics
  assign write_cmd_fire  = write_cmd_valid & write_cmd_ready;
  assign read_cmd_fire   = read_cmd_valid & read_cmd_ready;
  assign write_beat_fire = c2h_valid & c2h_ready;  // engine side
  assign read_beat_fire  = h2c_valid & h2c_ready;

  dsc_cmd_decode c2h_decode (  // writes feed the c2h engine
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .cmd_valid    (write_cmd_valid),
    .cmd_ready    (write_cmd_ready),
    .cmd_data     (write_cmd_data),
    .byp_ready    (c2h_dsc_byp_ready),
    .byp_load     (c2h_dsc_byp_load),
    .byp_addr     (c2h_dsc_byp_addr),
    .byp_len      (c2h_dsc_byp_len)
  );

  dsc_cmd_decode h2c_decode (  // reads feed the h2c engine
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .cmd_valid    (read_cmd_valid),
    .cmd_ready    (read_cmd_ready),
    .cmd_data     (read_cmd_data),
    .byp_ready    (h2c_dsc_byp_ready),
    .byp_load     (h2c_dsc_byp_load),
    .byp_addr     (h2c_dsc_byp_addr),
    .byp_len      (h2c_dsc_byp_len)
  );

  dir_stat_counters wr_stats (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .cmd_fire     (write_cmd_fire),
    .cmd_len      (write_cmd_data[dma_bypass_pkg::LEN_LSB +: dma_bypass_pkg::LEN_W]),
    .beat_fire    (write_beat_fire),
    .beat_last    (c2h_last),
    .reset_length (reset_write_length),
    .cmd_count    (wr_cmd_count),
    .word_count   (wr_word_count),
    .pkg_count    (wr_pkg_count),
    .length_count (wr_length_count)
  );

  dir_stat_counters rd_stats (
    .pcie_clk     (pcie_clk),
    .pcie_aresetn (pcie_aresetn),
    .cmd_fire     (read_cmd_fire),
    .cmd_len      (read_cmd_data[dma_bypass_pkg::LEN_LSB +: dma_bypass_pkg::LEN_W]),
    .beat_fire    (read_beat_fire),
    .beat_last    (h2c_last),
    .reset_length (reset_read_length),
    .cmd_count    (rd_cmd_count),
    .word_count   (rd_word_count),
    .pkg_count    (rd_pkg_count),
    .length_count (rd_length_count)
  );

  stat_readout readout (
    .pcie_clk        (pcie_clk),
    .pcie_aresetn    (pcie_aresetn),
    .stat_sel        (stat_sel),
    .wr_cmd_count    (wr_cmd_count),
    .wr_word_count   (wr_word_count),
    .wr_pkg_count    (wr_pkg_count),
    .wr_length_count (wr_length_count),
    .rd_cmd_count    (rd_cmd_count),
    .rd_word_count   (rd_word_count),
    .rd_pkg_count    (rd_pkg_count),
    .rd_length_count (rd_length_count),
    .stat_value      (stat_value)
  );

endmodule

//--- source/dsc_cmd_decode.sv
/*
 * descriptor bypass command decode
 * splits an accepted command into address and length and
 * raises a one-cycle load pulse toward the dma engine
 */
`timescale 1ns/1ps

module dsc_cmd_decode (
  input  logic                               pcie_clk,
  input  logic                               pcie_aresetn,
  // command from user side
  input  logic                               cmd_valid,
  output logic                               cmd_ready,
  input  logic [dma_bypass_pkg::CMD_W-1:0]   cmd_data,
  // descriptor bypass toward the engine
  input  logic                               byp_ready,
  output logic                               byp_load,
  output logic [dma_bypass_pkg::ADDR_W-1:0]  byp_addr,
  output logic [dma_bypass_pkg::LEN_W-1:0]   byp_len
);

  logic cmd_fire;

  // engine ready goes straight back, no skid buffer here
  assign cmd_ready = byp_ready;
  assign cmd_fire  = cmd_valid & byp_ready;

  // load is a single-cycle strobe
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      byp_load <= 1'b0;
    end else begin
      byp_load <= cmd_fire;
    end
  end

  // descriptor fields held until the next accepted command
  always_ff @(posedge pcie_clk) begin
    if (cmd_fire) begin
      byp_addr <= cmd_data[dma_bypass_pkg::ADDR_W-1:0];
      byp_len  <= cmd_data[dma_bypass_pkg::LEN_LSB +: dma_bypass_pkg::LEN_W];
    end
  end

endmodule

//--- source/stat_readout.sv
/*
 * statistics readout
 * registers the reads-flushed flag and returns one selected
 * counter, zero-extended, on a registered value port
 */
`timescale 1ns/1ps

module stat_readout (
  input  logic                                    pcie_clk,
  input  logic                                    pcie_aresetn,
  input  logic [dma_bypass_pkg::STAT_SEL_W-1:0]   stat_sel,
  // write direction
  input  logic [dma_bypass_pkg::CNT_W-1:0]        wr_cmd_count,
  input  logic [dma_bypass_pkg::CNT_W-1:0]        wr_word_count,
  input  logic [dma_bypass_pkg::CNT_W-1:0]        wr_pkg_count,
  input  logic [dma_bypass_pkg::LEN_CNT_W-1:0]    wr_length_count,
  // read direction
  input  logic [dma_bypass_pkg::CNT_W-1:0]        rd_cmd_count,
  input  logic [dma_bypass_pkg::CNT_W-1:0]        rd_word_count,
  input  logic [dma_bypass_pkg::CNT_W-1:0]        rd_pkg_count,
  input  logic [dma_bypass_pkg::LEN_CNT_W-1:0]    rd_length_count,
  output logic [dma_bypass_pkg::LEN_CNT_W-1:0]    stat_value
);

  logic reads_flushed;

  // pad a 32 bit event counter to readout width
  function automatic logic [dma_bypass_pkg::LEN_CNT_W-1:0] zext_cnt(
    input logic [dma_bypass_pkg::CNT_W-1:0] cnt
  );
    zext_cnt = {{(dma_bypass_pkg::LEN_CNT_W - dma_bypass_pkg::CNT_W){1'b0}}, cnt};
  endfunction

  // every read command has seen its last beat
  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      reads_flushed <= 1'b0;
    end else begin
      reads_flushed <= (rd_cmd_count == rd_pkg_count);
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (!pcie_aresetn) begin
      stat_value <= '0;
    end else begin
      case (stat_sel)
        dma_bypass_pkg::STAT_WR_CMD:  stat_value <= zext_cnt(wr_cmd_count);
        dma_bypass_pkg::STAT_WR_WORD: stat_value <= zext_cnt(wr_word_count);
        dma_bypass_pkg::STAT_WR_PKG:  stat_value <= zext_cnt(wr_pkg_count);
        dma_bypass_pkg::STAT_WR_LEN:  stat_value <= wr_length_count;
        dma_bypass_pkg::STAT_RD_CMD:  stat_value <= zext_cnt(rd_cmd_count);
        dma_bypass_pkg::STAT_RD_WORD: stat_value <= zext_cnt(rd_word_count);
        dma_bypass_pkg::STAT_RD_PKG:  stat_value <= zext_cnt(rd_pkg_count);
        dma_bypass_pkg::STAT_RD_LEN:  stat_value <= rd_length_count;
        dma_bypass_pkg::STAT_FLUSHED: begin
          stat_value <= {{(dma_bypass_pkg::LEN_CNT_W - 1){1'b0}}, reads_flushed};
        end
        default:                      stat_value <= '0;  // unmapped codes
      endcase
    end
  end

endmodule

//--- tests/dma_bypass_model.svh
/*
 * dma bypass reference model
 * predicts descriptors, per-direction counters and the registered
 * statistics readout, one step per clock from the driven inputs
 */
`ifndef DMA_BYPASS_MODEL_SVH
`define DMA_BYPASS_MODEL_SVH

logic exp_c2h_load, exp_h2c_load;
logic c2h_loaded, h2c_loaded;  // a descriptor has been held since reset
logic [dma_bypass_pkg::ADDR_W-1:0] exp_c2h_addr, exp_h2c_addr;
logic [dma_bypass_pkg::LEN_W-1:0] exp_c2h_len, exp_h2c_len;
logic [dma_bypass_pkg::CNT_W-1:0] m_wr_cmd, m_wr_word, m_wr_pkg;
logic [dma_bypass_pkg::CNT_W-1:0] m_rd_cmd, m_rd_word, m_rd_pkg;
logic [dma_bypass_pkg::LEN_CNT_W-1:0] m_wr_len, m_rd_len;
logic m_flushed;  // registered flag as the readout sees it
logic [dma_bypass_pkg::LEN_CNT_W-1:0] exp_stat;

task automatic model_reset();
  exp_c2h_load = 1'b0;
  exp_h2c_load = 1'b0;
  c2h_loaded   = 1'b0;
  h2c_loaded   = 1'b0;
  {m_wr_cmd, m_wr_word, m_wr_pkg, m_wr_len} = '0;
  {m_rd_cmd, m_rd_word, m_rd_pkg, m_rd_len} = '0;
  m_flushed = 1'b0;
  exp_stat  = '0;
endtask

// counters zero-extended to readout width, flag in bit 0
function automatic logic [dma_bypass_pkg::LEN_CNT_W-1:0] predict_stat(
  input logic [dma_bypass_pkg::STAT_SEL_W-1:0] sel
);
  logic [dma_bypass_pkg::LEN_CNT_W-1:0] v;
  v = '0;
  case (sel)
    dma_bypass_pkg::STAT_WR_CMD:  v[dma_bypass_pkg::CNT_W-1:0] = m_wr_cmd;
    dma_bypass_pkg::STAT_WR_WORD: v[dma_bypass_pkg::CNT_W-1:0] = m_wr_word;
    dma_bypass_pkg::STAT_WR_PKG:  v[dma_bypass_pkg::CNT_W-1:0] = m_wr_pkg;
    dma_bypass_pkg::STAT_WR_LEN:  v = m_wr_len;
    dma_bypass_pkg::STAT_RD_CMD:  v[dma_bypass_pkg::CNT_W-1:0] = m_rd_cmd;
    dma_bypass_pkg::STAT_RD_WORD: v[dma_bypass_pkg::CNT_W-1:0] = m_rd_word;
    dma_bypass_pkg::STAT_RD_PKG:  v[dma_bypass_pkg::CNT_W-1:0] = m_rd_pkg;
    dma_bypass_pkg::STAT_RD_LEN:  v = m_rd_len;
    dma_bypass_pkg::STAT_FLUSHED: v[0] = m_flushed;
    default:                      v = '0;  // unknown code
  endcase
  return v;
endfunction

// advance one clock using the inputs currently driven on the testbench nets
task automatic model_step();
  logic wr_fire;
  logic rd_fire;
  logic [dma_bypass_pkg::LEN_W-1:0] wr_len;
  logic [dma_bypass_pkg::LEN_W-1:0] rd_len;
  wr_fire = write_cmd_valid && c2h_dsc_byp_ready;
  rd_fire = read_cmd_valid && h2c_dsc_byp_ready;
  wr_len  = write_cmd_data[dma_bypass_pkg::LEN_LSB +: dma_bypass_pkg::LEN_W];
  rd_len  = read_cmd_data[dma_bypass_pkg::LEN_LSB +: dma_bypass_pkg::LEN_W];
  exp_stat  = predict_stat(stat_sel);  // readout sees counters before this step
  m_flushed = (m_rd_cmd == m_rd_pkg);
  exp_c2h_load = wr_fire;
  exp_h2c_load = rd_fire;
  if (wr_fire) begin
    exp_c2h_addr = write_cmd_data[dma_bypass_pkg::ADDR_W-1:0];
    exp_c2h_len  = wr_len;
    c2h_loaded   = 1'b1;
    m_wr_cmd     = m_wr_cmd + 1'b1;
  end
  if (rd_fire) begin
    exp_h2c_addr = read_cmd_data[dma_bypass_pkg::ADDR_W-1:0];
    exp_h2c_len  = rd_len;
    h2c_loaded   = 1'b1;
    m_rd_cmd     = m_rd_cmd + 1'b1;
  end
  if (write_data_valid && c2h_ready) begin  // beats count on the engine side
    m_wr_word = m_wr_word + 1'b1;
    if (write_data_last) m_wr_pkg = m_wr_pkg + 1'b1;
  end
  if (h2c_valid && read_data_ready) begin
    m_rd_word = m_rd_word + 1'b1;
    if (h2c_last) m_rd_pkg = m_rd_pkg + 1'b1;
  end
  if (reset_write_length) m_wr_len = '0;  // clear wins
  else if (wr_fire) m_wr_len = m_wr_len + wr_len;
  if (reset_read_length) m_rd_len = '0;
  else if (rd_fire) m_rd_len = m_rd_len + rd_len;
endtask

`endif

//--- tests/tb_dma_bypass.sv
/*
 * testbench for the dma bypass front end
 * random commands, streams and statistics selects against a model
 */
`timescale 1ns/1ps

module tb_dma_bypass;

  localparam int N_CYCLES     = 2000;
  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 5;

  logic pcie_clk, pcie_aresetn;
  logic write_cmd_valid, write_cmd_ready, read_cmd_valid, read_cmd_ready;
  logic [dma_bypass_pkg::CMD_W-1:0] write_cmd_data, read_cmd_data;
  logic write_data_valid, write_data_ready, write_data_last;
  logic read_data_valid, read_data_ready, read_data_last;
  logic c2h_valid, c2h_ready, c2h_last, h2c_valid, h2c_ready, h2c_last;
  logic [dma_bypass_pkg::DATA_W-1:0] write_data_data, read_data_data, c2h_data, h2c_data;
  logic [dma_bypass_pkg::KEEP_W-1:0] write_data_keep, read_data_keep, c2h_keep, h2c_keep;
  logic c2h_dsc_byp_ready, c2h_dsc_byp_load, h2c_dsc_byp_ready, h2c_dsc_byp_load;
  logic [dma_bypass_pkg::ADDR_W-1:0] c2h_dsc_byp_addr, h2c_dsc_byp_addr;
  logic [dma_bypass_pkg::LEN_W-1:0] c2h_dsc_byp_len, h2c_dsc_byp_len;
  logic [dma_bypass_pkg::STAT_SEL_W-1:0] stat_sel;
  logic reset_write_length, reset_read_length;
  logic [dma_bypass_pkg::LEN_CNT_W-1:0] stat_value;

  `include "dma_bypass_model.svh"

  dma_bypass_top DUT (.*);

  initial begin
    pcie_clk = 1'b0;
    forever #(CLK_PERIOD / 2) pcie_clk = ~pcie_clk;
  end

  task automatic end_failed();
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("ERR %0t: %s", $time, msg);
    end_failed();
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic check_desc(input string what,
                            input logic [dma_bypass_pkg::ADDR_W-1:0] got_addr,
                            input logic [dma_bypass_pkg::LEN_W-1:0] got_len,
                            input logic [dma_bypass_pkg::ADDR_W-1:0] exp_addr,
                            input logic [dma_bypass_pkg::LEN_W-1:0] exp_len);
    if (got_addr !== exp_addr || got_len !== exp_len) begin
      report_mismatch($sformatf("%s addr %h len %h, expected addr %h len %h",
                                what, got_addr, got_len, exp_addr, exp_len));
    end
  endtask

  task automatic check_stat(input logic [dma_bypass_pkg::LEN_CNT_W-1:0] got,
                            input logic [dma_bypass_pkg::LEN_CNT_W-1:0] exp);
    if (got !== exp) report_mismatch($sformatf("stat_value %h, expected %h", got, exp));
  endtask

  task automatic check_beat(input string what,
                            input logic [dma_bypass_pkg::DATA_W-1:0] got_data,
                            input logic [dma_bypass_pkg::KEEP_W-1:0] got_keep,
                            input logic got_last,
                            input logic [dma_bypass_pkg::DATA_W-1:0] exp_data,
                            input logic [dma_bypass_pkg::KEEP_W-1:0] exp_keep,
                            input logic exp_last);
    if (got_data !== exp_data || got_keep !== exp_keep || got_last !== exp_last) begin
      report_mismatch($sformatf("%s beat differs, keep %h last %b, expected keep %h last %b",
                                what, got_keep, got_last, exp_keep, exp_last));
    end
  endtask

  function automatic logic [dma_bypass_pkg::DATA_W-1:0] rand_data();
    logic [dma_bypass_pkg::DATA_W-1:0] d;
    for (int i = 0; i < dma_bypass_pkg::DATA_W / 32; i++) d[i*32 +: 32] = $urandom;
    return d;
  endfunction

  // one random cycle of stimulus, read cmd and read last rates roughly matched
  task automatic drive_random();
    write_cmd_valid    <= ($urandom_range(0, 1) == 1);
    write_cmd_data     <= {$urandom, $urandom, $urandom};
    c2h_dsc_byp_ready  <= ($urandom_range(0, 3) != 0);
    read_cmd_valid     <= ($urandom_range(0, 3) == 0);
    read_cmd_data      <= {$urandom, $urandom, $urandom};
    h2c_dsc_byp_ready  <= ($urandom_range(0, 3) != 0);
    write_data_valid   <= ($urandom_range(0, 1) == 1);
    write_data_data    <= rand_data();
    write_data_keep    <= {$urandom, $urandom};
    write_data_last    <= ($urandom_range(0, 3) == 0);
    c2h_ready          <= ($urandom_range(0, 3) != 0);
    h2c_valid          <= ($urandom_range(0, 2) == 0);
    h2c_data           <= rand_data();
    h2c_keep           <= {$urandom, $urandom};
    h2c_last           <= ($urandom_range(0, 3) != 0);
    read_data_ready    <= ($urandom_range(0, 3) != 0);
    stat_sel           <= $urandom_range(0, 10);  // 9 and 10 are unmapped
    reset_write_length <= ($urandom_range(0, 15) == 0);  // rare clears
    reset_read_length  <= ($urandom_range(0, 15) == 0);
  endtask

  // outputs settle between edges, compare on the falling edge
  always @(negedge pcie_clk) begin
    if (!pcie_aresetn) begin
      model_reset();
    end else begin
      check_bit("c2h_dsc_byp_load", c2h_dsc_byp_load, exp_c2h_load);
      check_bit("h2c_dsc_byp_load", h2c_dsc_byp_load, exp_h2c_load);
      if (c2h_loaded) begin
        check_desc("c2h", c2h_dsc_byp_addr, c2h_dsc_byp_len, exp_c2h_addr, exp_c2h_len);
      end
      if (h2c_loaded) begin
        check_desc("h2c", h2c_dsc_byp_addr, h2c_dsc_byp_len, exp_h2c_addr, exp_h2c_len);
      end
      check_bit("write_cmd_ready", write_cmd_ready, c2h_dsc_byp_ready);
      check_bit("read_cmd_ready", read_cmd_ready, h2c_dsc_byp_ready);
      check_bit("c2h_valid", c2h_valid, write_data_valid);
      check_bit("write_data_ready", write_data_ready, c2h_ready);
      check_beat("c2h", c2h_data, c2h_keep, c2h_last,
                 write_data_data, write_data_keep, write_data_last);
      check_bit("read_data_valid", read_data_valid, h2c_valid);
      check_bit("h2c_ready", h2c_ready, read_data_ready);
      check_beat("read", read_data_data, read_data_keep, read_data_last,
                 h2c_data, h2c_keep, h2c_last);
      check_stat(stat_value, exp_stat);
      model_step();
    end
  end

  initial begin
    #(N_CYCLES * CLK_PERIOD * 2);
    $display("timeout: the run took longer than its time budget");
    end_failed();
  end

  initial begin
    void'($urandom(32'h2879e44e));
    pcie_aresetn = 1'b0;
    {write_cmd_valid, read_cmd_valid, write_data_valid, h2c_valid} = '0;
    {write_cmd_data, read_cmd_data} = '0;
    {write_data_data, write_data_keep, write_data_last} = '0;
    {h2c_data, h2c_keep, h2c_last} = '0;
    {c2h_ready, read_data_ready, c2h_dsc_byp_ready, h2c_dsc_byp_ready} = '0;
    stat_sel = '0;
    {reset_write_length, reset_read_length} = '0;
    repeat (RESET_CYCLES) @(posedge pcie_clk);
    pcie_aresetn <= 1'b1;
    repeat (N_CYCLES) begin
      @(posedge pcie_clk);
      drive_random();
    end
    @(posedge pcie_clk);
    {write_cmd_valid, read_cmd_valid, write_data_valid, h2c_valid} <= '0;
    repeat (3) @(posedge pcie_clk);  // drain the last compares
    $display("TEST OK");
    $finish;
  end

endmodule
